/* capture_macros.svh */
// Shared compile-time constants for the capture subsystem; include in RTL and testbench files
`ifndef CAPTURE_MACROS_SVH
`define CAPTURE_MACROS_SVH

// log2 of the capture depth in words (64 words)
`define CAP_COUNT_WIDTH 6

// Raw and averaged sample width
`define CAP_SAMPLE_WIDTH 16

// APB address width
`define CAP_PADDR_WIDTH 12

// APB register map, byte offsets
`define CAP_REG_CTRL 12'h000
`define CAP_REG_STATUS 12'h004

// Start of the RAM read window, one word per 4 bytes
`define CAP_RAM_BASE 12'h100

// Largest averaging exponent, larger written values are clamped to this
`define CAP_MAX_DECIM_LOG2 8

`endif

/* capture_pkg.sv */
// Common types for the capture subsystem; referenced by scoped name from RTL and testbench
`include "capture_macros.svh"

package capture_pkg;

  // One raw or averaged sample
  typedef logic [`CAP_SAMPLE_WIDTH-1:0] sample_t;

  // APB data word, also one RAM word
  // Samples sit zero-extended in the low bits
  typedef logic [31:0] word_t;

  // Byte address out of the address counter
  typedef logic [31:0] byte_addr_t;

  // APB address
  typedef logic [`CAP_PADDR_WIDTH-1:0] apb_addr_t;

  // Averaging exponent k, block size is 2^k
  typedef logic [3:0] decim_t;

  // APB slave states
  // st_wait is the first access cycle (pready low)
  // st_resp is the second access cycle (pready high)
  typedef enum logic [1:0] {
    st_idle,
    st_wait,
    st_resp
  } apb_state_t;

endpackage

/* sample_decimator.sv */
// Block-averaging decimator; sums 2^decim valid samples and strobes clken with the mean
`timescale 1ns/10ps
`include "capture_macros.svh"

module sample_decimator (
  input  logic                 clk,
  input  logic                 rst,
  input  capture_pkg::sample_t sample_in,
  input  logic                 sample_valid,
  input  logic                 enable,
  input  logic                 restart,
  input  capture_pkg::decim_t  decim,
  output capture_pkg::sample_t avg_sample,
  output logic                 clken
);

  // Accumulator holds up to 2^max_k full-scale samples
  localparam int ACC_WIDTH = `CAP_SAMPLE_WIDTH + `CAP_MAX_DECIM_LOG2;
  // Sample counter reaches 2^max_k - 1
  localparam int CNT_WIDTH = `CAP_MAX_DECIM_LOG2 + 1;

  logic [ACC_WIDTH-1:0] acc;
  logic [ACC_WIDTH-1:0] sum;
  logic [CNT_WIDTH-1:0] count;
  logic [CNT_WIDTH-1:0] last_count;
  logic                 accept;
  logic                 block_done;

  // Index of the final sample in the current block
  assign last_count = (CNT_WIDTH'(1) << decim) - CNT_WIDTH'(1);

  // Running sum including the sample on the input this cycle
  assign sum = acc + ACC_WIDTH'(sample_in);

  // A CTRL write discards the sample arriving with it
  assign accept = enable && sample_valid && !restart;
  assign block_done = accept && (count == last_count);

  always_ff @(posedge clk) begin
    if (rst) begin
      acc   <= '0;
      count <= '0;
      clken <= 1'b0;
    end else begin
      // Strobe lands one cycle after the last sample of a block
      clken <= block_done;
      if (restart || !enable) begin
        // Drop any partial block
        acc   <= '0;
        count <= '0;
      end else if (block_done) begin
        acc   <= '0;
        count <= '0;
      end else if (accept) begin
        acc   <= sum;
        count <= count + CNT_WIDTH'(1);
      end
    end
  end

  // Mean of the block, held until the next block completes
  always_ff @(posedge clk) begin
    if (block_done) begin
      avg_sample <= capture_pkg::sample_t'(sum >> decim);
    end
  end

endmodule

/* address_counter.sv */
// Circular word-address generator for the capture RAM; arms the write enable per sweep on trigger
`timescale 1ns/10ps
`include "capture_macros.svh"

module address_counter #(
  parameter int COUNT_WIDTH = `CAP_COUNT_WIDTH
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    clken,
  input  logic                    trig,
  output capture_pkg::byte_addr_t address,
  output logic [3:0]              wen,
  output logic                    wrap
);

  // Word index of the last RAM location
  localparam logic [COUNT_WIDTH-1:0] MAX_COUNT = '1;

  logic [COUNT_WIDTH-1:0] count;
  logic                   trig_q;
  logic                   trig_rise;
  logic                   seen_trig;

  // Byte address is the word index times 4, upper bits zero
  assign address = capture_pkg::byte_addr_t'({count, 2'b00});

  // Last write of the sweep happens in this cycle
  assign wrap = clken && (count == MAX_COUNT);

  assign trig_rise = trig && !trig_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      count     <= '0;
      trig_q    <= 1'b0;
      seen_trig <= 1'b0;
      wen       <= 4'b0000;
    end else begin
      trig_q <= trig;

      // Step one word per strobe, back to 0 after the top
      if (wrap) begin
        count <= '0;
      end else if (clken) begin
        count <= count + 1'b1;
      end

      if (wrap) begin
        // Next sweep writes only if a trigger arrived during this one
        wen <= {4{seen_trig}};
        // Edge in the wrap cycle itself belongs to the next sweep
        seen_trig <= trig_rise;
      end else if (trig_rise) begin
        seen_trig <= 1'b1;
      end
    end
  end

endmodule

/* capture_ram.sv */
// Capture buffer RAM; byte-lane writes from the sample path, registered reads for the APB window
`timescale 1ns/10ps
`include "capture_macros.svh"

module capture_ram #(
  parameter int DEPTH_LOG2 = `CAP_COUNT_WIDTH
) (
  input  logic                  clk,
  input  logic [3:0]            we,
  input  logic [DEPTH_LOG2-1:0] waddr,
  input  logic [DEPTH_LOG2-1:0] raddr,
  input  capture_pkg::word_t    wdata,
  output capture_pkg::word_t    rdata
);

  localparam int DEPTH = 1 << DEPTH_LOG2;

  // Storage has no reset, only written words are ever read back
  capture_pkg::word_t mem [0:DEPTH-1];

  // Write port, one enable per byte lane
  always_ff @(posedge clk) begin
    for (int lane = 0; lane < 4; lane++) begin
      if (we[lane]) begin
        mem[waddr][8*lane +: 8] <= wdata[8*lane +: 8];
      end
    end
  end

  // Read port
  // Data follows the address by one cycle
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

/* capture_apb_regs.sv */
// APB slave for capture control, status and a read window into the capture RAM
`timescale 1ns/10ps
`include "capture_macros.svh"

module capture_apb_regs (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  capture_pkg::apb_addr_t        paddr,
  input  capture_pkg::word_t            pwdata,
  output capture_pkg::word_t            prdata,
  output logic                          pready,
  output logic                          pslverr,
  output capture_pkg::decim_t           decim,
  output logic                          enable,
  output logic                          restart,
  input  logic                          wrap,
  input  logic                          wen_state,
  output logic [`CAP_COUNT_WIDTH-1:0]   ram_raddr,
  input  capture_pkg::word_t            ram_rdata
);

  // Size of the RAM window in bytes
  localparam capture_pkg::apb_addr_t RAM_BYTES =
    capture_pkg::apb_addr_t'(4 << `CAP_COUNT_WIDTH);
  localparam capture_pkg::decim_t MAX_DECIM = capture_pkg::decim_t'(`CAP_MAX_DECIM_LOG2);

  capture_pkg::apb_state_t state;
  capture_pkg::apb_addr_t  ram_offset;
  capture_pkg::word_t      ctrl_word;
  capture_pkg::word_t      status_word;
  capture_pkg::decim_t     wr_decim;
  logic [7:0]              sweep_count;
  logic                    is_ctrl;
  logic                    is_status;
  logic                    is_ram;
  logic                    addr_err;
  logic                    access_done;

  // Address decode
  assign is_ctrl    = (paddr == `CAP_REG_CTRL);
  assign is_status  = (paddr == `CAP_REG_STATUS);
  assign ram_offset = paddr - `CAP_RAM_BASE;
  assign is_ram     = (paddr >= `CAP_RAM_BASE) && (ram_offset < RAM_BYTES) &&
                      (paddr[1:0] == 2'b00);

  // Only CTRL is writable and everything mapped is readable
  assign addr_err = pwrite ? !is_ctrl : !(is_ctrl || is_status || is_ram);

  // RAM word index taken from paddr during the wait cycle
  assign ram_raddr = ram_offset[`CAP_COUNT_WIDTH+1:2];

  // Register images
  assign ctrl_word   = {27'b0, enable, decim};
  assign status_word = {16'b0, sweep_count, 7'b0, wen_state};

  // Second access cycle completes the transfer
  assign access_done = (state == capture_pkg::st_resp);
  assign pready      = access_done;
  assign pslverr     = access_done && addr_err;

  // CTRL write strobe that also flushes the decimator
  assign restart = access_done && pwrite && is_ctrl;

  // Out-of-range exponents saturate
  assign wr_decim = (pwdata[3:0] > MAX_DECIM) ? MAX_DECIM : pwdata[3:0];

  // One wait state per transfer
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= capture_pkg::st_idle;
    end else begin
      case (state)
        capture_pkg::st_idle: begin
          // Setup phase seen
          if (psel && !penable) begin
            state <= capture_pkg::st_wait;
          end
        end
        capture_pkg::st_wait: begin
          if (psel && penable) begin
            state <= capture_pkg::st_resp;
          end else begin
            // Master dropped the transfer
            state <= capture_pkg::st_idle;
          end
        end
        default: state <= capture_pkg::st_idle;
      endcase
    end
  end

  // CTRL register and sweep counter
  always_ff @(posedge clk) begin
    if (rst) begin
      decim       <= '0;
      enable      <= 1'b0;
      sweep_count <= '0;
    end else begin
      if (restart) begin
        decim  <= wr_decim;
        enable <= pwdata[4];
      end
      // Counts modulo 256
      if (wrap) begin
        sweep_count <= sweep_count + 8'd1;
      end
    end
  end

  // Read mux with RAM data from the read issued in st_wait
  always_comb begin
    prdata = '0;
    if (access_done && !pwrite) begin
      if (is_ctrl) begin
        prdata = ctrl_word;
      end else if (is_status) begin
        prdata = status_word;
      end else if (is_ram) begin
        prdata = ram_rdata;
      end
    end
  end

endmodule

/* capture_top.sv */
// Top level of the capture subsystem; decimator feeds the address counter and RAM, APB reads it out
`timescale 1ns/10ps
`include "capture_macros.svh"

module capture_top (
  input  logic                   clk,
  input  logic                   rst,
  input  capture_pkg::sample_t   sample_in,
  input  logic                   sample_valid,
  input  logic                   trig,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  capture_pkg::apb_addr_t paddr,
  input  capture_pkg::word_t     pwdata,
  output capture_pkg::word_t     prdata,
  output logic                   pready,
  output logic                   pslverr
);

  capture_pkg::sample_t    avg_sample;
  capture_pkg::byte_addr_t address;
  capture_pkg::decim_t     decim;
  capture_pkg::word_t      ram_wdata;
  capture_pkg::word_t      ram_rdata;
  logic [3:0]              wen;
  logic [3:0]              ram_we;
  logic [`CAP_COUNT_WIDTH-1:0] ram_raddr;
  logic                    clken;
  logic                    wrap;
  logic                    enable;
  logic                    restart;

  // Writes only on strobe cycles of an armed sweep
  assign ram_we    = wen & {4{clken}};
  assign ram_wdata = {{(32-`CAP_SAMPLE_WIDTH){1'b0}}, avg_sample};

  sample_decimator decimator_i (
    .clk          (clk),
    .rst          (rst),
    .sample_in    (sample_in),
    .sample_valid (sample_valid),
    .enable       (enable),
    .restart      (restart),
    .decim        (decim),
    .avg_sample   (avg_sample),
    .clken        (clken)
  );

  address_counter #(.COUNT_WIDTH(`CAP_COUNT_WIDTH)) counter_i (
    .clk     (clk),
    .rst     (rst),
    .clken   (clken),
    .trig    (trig),
    .address (address),
    .wen     (wen),
    .wrap    (wrap)
  );

  // Word index comes from the byte address
  capture_ram #(.DEPTH_LOG2(`CAP_COUNT_WIDTH)) ram_i (
    .clk   (clk),
    .we    (ram_we),
    .waddr (address[`CAP_COUNT_WIDTH+1:2]),
    .raddr (ram_raddr),
    .wdata (ram_wdata),
    .rdata (ram_rdata)
  );

  capture_apb_regs regs_i (
    .clk       (clk),
    .rst       (rst),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .decim     (decim),
    .enable    (enable),
    .restart   (restart),
    .wrap      (wrap),
    .wen_state (wen[0]),
    .ram_raddr (ram_raddr),
    .ram_rdata (ram_rdata)
  );

endmodule

/* address_counter_props.sv */
// Concurrent checks on address stepping and sweep write enable that bind into every address_counter
`timescale 1ns/10ps
`include "capture_macros.svh"

module address_counter_props #(
  parameter int COUNT_WIDTH = `CAP_COUNT_WIDTH
) (
  input logic                    clk,
  input logic                    rst,
  input logic                    clken,
  input logic                    trig,
  input capture_pkg::byte_addr_t address,
  input logic [3:0]              wen,
  input logic                    wrap,
  input logic                    seen_trig
);

  // Byte address of the top word
  localparam logic [31:0] MAX_ADDR = ((32'd1 << COUNT_WIDTH) - 32'd1) << 2;

  a_hold: assert property (@(posedge clk) disable iff (rst) !clken |=> $stable(address))
    else $error("address moved without clken");

  a_step: assert property (@(posedge clk) disable iff (rst)
    clken && (address != MAX_ADDR) |=> address == $past(address) + 32'd4)
    else $error("address did not step by 4");

  // Strobe at the top word returns the address to 0
  a_wrap: assert property (@(posedge clk) disable iff (rst)
    clken && (address == MAX_ADDR) |=> address == '0)
    else $error("address did not wrap to 0");

  a_wen_hold: assert property (@(posedge clk) disable iff (rst) !wrap |=> $stable(wen))
    else $error("wen changed outside a wrap");

  a_wen_flag: assert property (@(posedge clk) disable iff (rst)
    wrap |=> wen == {4{$past(seen_trig)}})
    else $error("wen not taken from the trigger flag");

  // Edge in the wrap cycle arms the sweep after next only
  a_late_trig: assert property (@(posedge clk) disable iff (rst)
    wrap && !seen_trig && trig && !$past(trig) |=> wen == 4'b0000)
    else $error("trigger in the wrap cycle armed the next sweep");

endmodule

bind address_counter address_counter_props #(.COUNT_WIDTH(COUNT_WIDTH)) props_i (
  .clk       (clk),
  .rst       (rst),
  .clken     (clken),
  .trig      (trig),
  .address   (address),
  .wen       (wen),
  .wrap      (wrap),
  .seen_trig (seen_trig)
);

/* capture_tb.sv */
// Directed testbench for capture_top; streams LFSR samples and triggers, checks registers and RAM
`timescale 1ns/10ps
`include "capture_macros.svh"

module capture_tb;

  localparam int WORDS = 1 << `CAP_COUNT_WIDTH;
  // Generous bound for one APB transfer
  localparam int APB_CYC = 5;
  // Worst-case cycles of reset and the six tests in order
  localparam int TEST_CYC = 16 + 4 * APB_CYC + (2 * APB_CYC + 2 * WORDS + 2) +
                            (2 * WORDS + 4 + 67 * APB_CYC) + (8 * WORDS + 4 + 68 * APB_CYC) +
                            (8 * WORDS + 4 + 67 * APB_CYC) + 2 * APB_CYC;
  localparam int TIMEOUT = 2 * TEST_CYC;

  logic                   clk;
  logic                   rst;
  capture_pkg::sample_t   sample_in;
  logic                   sample_valid;
  logic                   trig;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  capture_pkg::apb_addr_t paddr;
  capture_pkg::word_t     pwdata;
  capture_pkg::word_t     prdata;
  logic                   pready;
  logic                   pslverr;

  // Reference model of decimator, sweep position and arming
  capture_pkg::word_t   exp_mem [0:WORDS-1];
  int                   m_pos;
  int                   m_sweeps;
  int                   m_k;
  int                   m_cnt;
  logic [23:0]          m_acc;
  capture_pkg::sample_t m_avg;
  logic                 m_clken;
  logic                 m_armed;
  logic                 m_seen;
  logic                 m_trig_q;
  logic [31:0]          lfsr;
  int                   cycles = 0;

  capture_top capture_top_i (
    .clk          (clk),
    .rst          (rst),
    .sample_in    (sample_in),
    .sample_valid (sample_valid),
    .trig         (trig),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("timeout after %0d cycles, the tests did not complete", cycles);
      $display("** FAIL **");
      $fatal(1, "run limit reached");
    end
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per sample bit
  task automatic take_sample(output capture_pkg::sample_t s);
    s = '0;
    for (int i = 0; i < `CAP_SAMPLE_WIDTH; i++) begin
      s = {s[`CAP_SAMPLE_WIDTH-2:0], lfsr[31]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (actual !== expected) begin
      $display("mismatch %s expected %h actual %h", name, expected, actual);
      $display("** FAIL **");
      $fatal(1, "value check failed");
    end
  endtask

  // One clock of the model, strobe and trigger seen in the same cycle as the DUT
  task automatic model_cycle(input logic valid, input capture_pkg::sample_t s, input logic t);
    logic rise;
    logic wrap_now;
    rise = t && !m_trig_q;
    wrap_now = m_clken && (m_pos == WORDS - 1);
    if (m_clken && m_armed) begin
      exp_mem[m_pos] = {16'b0, m_avg};
    end
    if (wrap_now) begin
      // Arming for the next sweep, an edge right now counts for the one after
      m_armed = m_seen;
      m_seen = rise;
      m_pos = 0;
      m_sweeps++;
    end else begin
      if (m_clken) begin
        m_pos++;
      end
      if (rise) begin
        m_seen = 1'b1;
      end
    end
    m_trig_q = t;
    m_clken = 1'b0;
    if (valid) begin
      m_acc = m_acc + 24'(s);
      m_cnt++;
      // Block of 2^k done, mean strobes next cycle
      if (m_cnt == (1 << m_k)) begin
        m_avg = capture_pkg::sample_t'(m_acc >> m_k);
        m_clken = 1'b1;
        m_acc = '0;
        m_cnt = 0;
      end
    end
  endtask

  // Setup, one access cycle with pready low, then the completing cycle
  task automatic bus_transfer(input logic wr, input capture_pkg::apb_addr_t addr,
                              input capture_pkg::word_t wdata,
                              output capture_pkg::word_t rdata, output logic err);
    int waits;
    waits = 0;
    @(posedge clk);
    #1;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = wr;
    paddr = addr;
    pwdata = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    @(negedge clk);
    while (!pready) begin
      waits++;
      @(negedge clk);
    end
    rdata = prdata;
    err = pslverr;
    @(posedge clk);
    #1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    check_eq("apb wait states", 1, waits);
  endtask

  task automatic apb_write(input capture_pkg::apb_addr_t addr, input capture_pkg::word_t data,
                           output logic err);
    capture_pkg::word_t unused;
    bus_transfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input capture_pkg::apb_addr_t addr, output capture_pkg::word_t data,
                          output logic err);
    bus_transfer(1'b0, addr, '0, data, err);
  endtask

  task automatic write_ctrl(input capture_pkg::word_t value);
    logic err;
    apb_write(`CAP_REG_CTRL, value, err);
    check_eq("ctrl write pslverr", 0, err);
    // Clamp and partial-block flush
    m_k = (value[3:0] > `CAP_MAX_DECIM_LOG2) ? `CAP_MAX_DECIM_LOG2 : value[3:0];
    m_acc = '0;
    m_cnt = 0;
  endtask

  task automatic check_status(input string name);
    capture_pkg::word_t d;
    logic err;
    apb_read(`CAP_REG_STATUS, d, err);
    check_eq(name, {16'b0, 8'(m_sweeps), 7'b0, m_armed}, d);
  endtask

  task automatic check_ram(input string name);
    capture_pkg::word_t d;
    logic err;
    for (int i = 0; i < WORDS; i++) begin
      apb_read(capture_pkg::apb_addr_t'(`CAP_RAM_BASE + 4 * i), d, err);
      check_eq($sformatf("%s word %0d", name, i), exp_mem[i], d);
    end
  endtask

  // n valid samples, a flush cycle, then trig low; trig_cycle < 0 means no trigger
  task automatic stream(input int n, input int trig_cycle);
    capture_pkg::sample_t s;
    logic valid;
    logic t;
    for (int c = 0; c <= n + 1; c++) begin
      @(posedge clk);
      #1;
      valid = (c < n);
      t = (c == trig_cycle);
      s = '0;
      if (valid) begin
        take_sample(s);
      end
      sample_in = s;
      sample_valid = valid;
      trig = t;
      model_cycle(valid, s, t);
    end
  endtask

  task automatic reset_values();
    capture_pkg::word_t d;
    logic err;
    apb_read(`CAP_REG_CTRL, d, err);
    check_eq("reset ctrl", 0, d);
    check_eq("reset ctrl pslverr", 0, err);
    apb_read(`CAP_REG_STATUS, d, err);
    check_eq("reset status", 0, d);
    apb_write(`CAP_REG_STATUS, 32'h1, err);
    check_eq("status write pslverr", 1, err);
    apb_read(12'h008, d, err);
    check_eq("unmapped read pslverr", 1, err);
  endtask

  task automatic idle_sweeps();
    write_ctrl(32'h10);
    stream(2 * WORDS, -1);
    check_status("idle sweeps status");
  endtask

  // Trigger mid-sweep arms exactly the following sweep
  task automatic trigger_sweep(input int k, input int trig_cycle);
    if (k != m_k) begin
      write_ctrl(32'h10 | k);
    end
    stream(WORDS << k, trig_cycle);
    check_status($sformatf("k%0d armed status", k));
    stream(WORDS << k, -1);
    check_status($sformatf("k%0d disarmed status", k));
    check_ram($sformatf("k%0d ram", k));
  endtask

  task automatic wrap_trigger();
    int wrap_cycle;
    // Cycle where the strobe for the top word lands
    wrap_cycle = (WORDS - m_pos) << m_k;
    stream(WORDS << m_k, wrap_cycle);
    check_status("wrap trigger status");
    stream(WORDS << m_k, -1);
    check_status("after wrap trigger status");
    check_ram("wrap trigger ram");
  endtask

  task automatic decim_clamp();
    capture_pkg::word_t d;
    logic err;
    write_ctrl(32'h0C);
    apb_read(`CAP_REG_CTRL, d, err);
    check_eq("decim clamp", 32'h08, d);
  endtask

  initial begin
    rst = 1'b1;
    sample_in = '0;
    sample_valid = 1'b0;
    trig = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    lfsr = 32'h5882;
    m_pos = 0;
    m_sweeps = 0;
    m_k = 0;
    m_cnt = 0;
    m_acc = '0;
    m_avg = '0;
    m_clken = 1'b0;
    m_armed = 1'b0;
    m_seen = 1'b0;
    m_trig_q = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    reset_values();
    idle_sweeps();
    trigger_sweep(0, 20);
    trigger_sweep(2, 100);
    wrap_trigger();
    decim_clamp();
    $display("** PASS **");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+.
capture_pkg.sv
sample_decimator.sv
address_counter.sv
capture_ram.sv
capture_apb_regs.sv
capture_top.sv
address_counter_props.sv
capture_tb.sv
